// File: logic/core_config.svh
// ****************************************
// core build parameters
// ****************************************
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define CORE_XLEN       32   // data path width
`define CORE_IMEM_WORDS 256  // words
`define CORE_DMEM_WORDS 256
`define CORE_HALT_CODE  10   // x17 value that ends the run

`endif

// File: logic/rv_isa_pkg.sv
// ****************************************
// rv32i encodings and decode types
// ****************************************
`default_nettype none

package rv_isa_pkg;

  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_slt, alu_sll, alu_srl, alu_sra,
    alu_pass_b  // lui
  } alu_op_e;

  // r and i formats
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_view_t;

  // s and b formats, immediate split around rs1/rs2
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } sb_view_t;

  typedef union packed {
    r_view_t  r_view;
    sb_view_t sb_view;
  } inst_u;

  typedef struct packed {
    logic wb_en;
    logic mem_rd;
    logic mem_wr;
    logic op1_pc;     // pc relative target
    logic op2_imm;
    logic is_branch;
    logic is_jal;
    logic is_jalr;
    logic is_ecall;
    logic rs1_used;
    logic rs2_used;
  } ctrl_t;

endpackage

`default_nettype wire

// File: logic/pipe_pkg.sv
// ****************************************
// pipeline register layouts
// ****************************************
`include "core_config.svh"
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic                  valid;
    logic [`CORE_XLEN-1:0] pc;
    rv_isa_pkg::inst_u     inst;
  } if_id_t;

  typedef struct packed {
    logic                  valid;
    rv_isa_pkg::ctrl_t     ctrl;
    rv_isa_pkg::alu_op_e   alu_op;
    logic [2:0]            funct3;   // branch condition
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [4:0]            rd;
    logic                  halt;
  } id_ex_t;

  typedef struct packed {
    logic                  valid;
    logic                  wb_en;
    logic                  mem_rd;
    logic                  mem_wr;
    logic                  halt;
    logic [`CORE_XLEN-1:0] alu_out;   // also the data address
    logic [`CORE_XLEN-1:0] store_val;
    logic [4:0]            rd;
  } ex_mem_t;

  typedef struct packed {
    logic                  valid;
    logic                  wb_en;
    logic                  halt;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] rd_val;
  } mem_wb_t;

  typedef enum logic [1:0] {
    fwd_none     = 2'd0,
    fwd_from_mem = 2'd1,
    fwd_from_wb  = 2'd2
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: logic/decode_unit.sv
// ****************************************
// instruction decoder
// ****************************************
`default_nettype none

module decode_unit (
  input  rv_isa_pkg::inst_u   inst,
  output rv_isa_pkg::ctrl_t   ctrl,
  output rv_isa_pkg::alu_op_e alu_op,
  output logic [31:0]         imm
);
  import rv_isa_pkg::*;

  logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic        alt;  // funct7 bit 5, sub and sra

  function automatic alu_op_e alu_sel(input logic [2:0] funct3, input logic is_reg,
                                      input logic alt_bit);
    case (funct3)
      3'b000:  return (is_reg && alt_bit) ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b100:  return alu_xor;
      3'b101:  return alt_bit ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      3'b111:  return alu_and;
      default: return alu_add;
    endcase
  endfunction

  assign alt = inst.r_view.funct7[5];

  assign imm_i = {{20{inst.r_view.funct7[6]}}, inst.r_view.funct7, inst.r_view.rs2};
  assign imm_s = {{20{inst.sb_view.imm_hi[6]}}, inst.sb_view.imm_hi, inst.sb_view.imm_lo};
  assign imm_b = {{20{inst.sb_view.imm_hi[6]}}, inst.sb_view.imm_lo[0],
                  inst.sb_view.imm_hi[5:0], inst.sb_view.imm_lo[4:1], 1'b0};
  assign imm_u = {inst.r_view.funct7, inst.r_view.rs2, inst.r_view.rs1,
                  inst.r_view.funct3, 12'b0};
  // j immediate scattered over the r fields
  assign imm_j = {{12{inst.r_view.funct7[6]}}, inst.r_view.rs1, inst.r_view.funct3,
                  inst.r_view.rs2[0], inst.r_view.funct7[5:0], inst.r_view.rs2[4:1], 1'b0};

  always_comb begin
    ctrl   = '0;
    alu_op = alu_add;
    imm    = imm_i;
    case (inst.r_view.opcode)
      opc_op: begin
        ctrl.wb_en    = 1'b1;
        ctrl.rs1_used = 1'b1;
        ctrl.rs2_used = 1'b1;
        alu_op        = alu_sel(inst.r_view.funct3, 1'b1, alt);
      end
      opc_op_imm: begin
        ctrl.wb_en    = 1'b1;
        ctrl.op2_imm  = 1'b1;
        ctrl.rs1_used = 1'b1;
        alu_op        = alu_sel(inst.r_view.funct3, 1'b0, alt);
      end
      opc_lui: begin
        ctrl.wb_en   = 1'b1;
        ctrl.op2_imm = 1'b1;
        alu_op       = alu_pass_b;
        imm          = imm_u;
      end
      opc_load: begin
        ctrl.wb_en    = 1'b1;
        ctrl.mem_rd   = 1'b1;
        ctrl.op2_imm  = 1'b1;
        ctrl.rs1_used = 1'b1;
      end
      opc_store: begin
        ctrl.mem_wr   = 1'b1;
        ctrl.op2_imm  = 1'b1;
        ctrl.rs1_used = 1'b1;
        ctrl.rs2_used = 1'b1;
        imm           = imm_s;
      end
      opc_branch: begin
        ctrl.is_branch = 1'b1;
        ctrl.op1_pc    = 1'b1;
        ctrl.rs1_used  = 1'b1;
        ctrl.rs2_used  = 1'b1;
        alu_op         = alu_sub;  // compare by difference
        imm            = imm_b;
      end
      opc_jal: begin
        ctrl.wb_en  = 1'b1;
        ctrl.is_jal = 1'b1;
        ctrl.op1_pc = 1'b1;
        imm         = imm_j;
      end
      opc_jalr: begin
        ctrl.wb_en    = 1'b1;
        ctrl.is_jalr  = 1'b1;
        ctrl.rs1_used = 1'b1;
      end
      opc_system: begin
        ctrl.is_ecall = (inst.r_view.funct3 == 3'b000);
        ctrl.rs1_used = ctrl.is_ecall;  // reads x17
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
// ****************************************
// stall detection
// ****************************************
`default_nettype none

module hazard_unit (
  input  rv_isa_pkg::ctrl_t ctrl,
  input  logic [4:0]        rs1,
  input  logic [4:0]        rs2,
  input  pipe_pkg::id_ex_t  ex_stage,
  input  pipe_pkg::ex_mem_t mem_stage,
  output logic              stall
);

  logic load_in_ex;
  logic load_use;
  logic ecall_wait;

  assign load_in_ex = ex_stage.valid && ex_stage.ctrl.mem_rd && (ex_stage.rd != 5'd0);

  // load result is not ready before mem
  assign load_use = load_in_ex &&
                    ((ctrl.rs1_used && (rs1 == ex_stage.rd)) ||
                     (ctrl.rs2_used && (rs2 == ex_stage.rd)));

  // ecall compares x17 in decode, so every older writer must reach wb first
  assign ecall_wait = ctrl.is_ecall &&
                      ((ex_stage.valid && ex_stage.ctrl.wb_en && (ex_stage.rd == rs1)) ||
                       (mem_stage.valid && mem_stage.wb_en && (mem_stage.rd == rs1)));

  assign stall = load_use || ecall_wait;

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
// ****************************************
// execute stage
// ****************************************
`include "core_config.svh"
`default_nettype none

module execute_unit (
  input  pipe_pkg::id_ex_t      ex_stage,
  input  pipe_pkg::ex_mem_t     mem_stage,
  input  pipe_pkg::mem_wb_t     wb_stage,
  input  logic [`CORE_XLEN-1:0] predicted_pc,
  output logic [`CORE_XLEN-1:0] alu_out,
  output logic [`CORE_XLEN-1:0] store_val,
  output logic [`CORE_XLEN-1:0] next_pc,
  output logic                  redirect
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  fwd_sel_e              sel_a, sel_b;
  logic [`CORE_XLEN-1:0] op_a, rs2_fwd, op_b;
  logic [`CORE_XLEN-1:0] alu_res, target, pc_plus4;
  logic                  lt, cond, taken;

  // younger producer wins, loads in mem are not ready yet
  function automatic fwd_sel_e fwd_pick(input logic [4:0] rs, input ex_mem_t mem_s,
                                        input mem_wb_t wb_s);
    if (rs == 5'd0)
      return fwd_none;
    if (mem_s.valid && mem_s.wb_en && !mem_s.mem_rd && (mem_s.rd == rs))
      return fwd_from_mem;
    if (wb_s.valid && wb_s.wb_en && (wb_s.rd == rs))
      return fwd_from_wb;
    return fwd_none;
  endfunction

  assign sel_a = fwd_pick(ex_stage.rs1, mem_stage, wb_stage);
  assign sel_b = fwd_pick(ex_stage.rs2, mem_stage, wb_stage);

  always_comb begin
    case (sel_a)
      fwd_from_mem: op_a = mem_stage.alu_out;
      fwd_from_wb:  op_a = wb_stage.rd_val;
      default:      op_a = ex_stage.rs1_val;
    endcase
    case (sel_b)
      fwd_from_mem: rs2_fwd = mem_stage.alu_out;
      fwd_from_wb:  rs2_fwd = wb_stage.rd_val;
      default:      rs2_fwd = ex_stage.rs2_val;
    endcase
  end

  assign op_b = ex_stage.ctrl.op2_imm ? ex_stage.imm : rs2_fwd;
  assign lt   = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (ex_stage.alu_op)
      alu_sub:    alu_res = op_a - op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_or:     alu_res = op_a | op_b;
      alu_xor:    alu_res = op_a ^ op_b;
      alu_slt:    alu_res = {{(`CORE_XLEN-1){1'b0}}, lt};
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  always_comb begin
    case (ex_stage.funct3)
      3'b000:  cond = (alu_res == '0);  // beq
      3'b001:  cond = (alu_res != '0);
      3'b100:  cond = lt;               // blt
      3'b101:  cond = !lt;
      default: cond = 1'b0;
    endcase
  end

  assign pc_plus4 = ex_stage.pc + `CORE_XLEN'd4;
  assign target   = ((ex_stage.ctrl.op1_pc ? ex_stage.pc : op_a) + ex_stage.imm) &
                    ~`CORE_XLEN'(ex_stage.ctrl.is_jalr);  // jalr clears bit 0
  assign taken    = ex_stage.ctrl.is_jal || ex_stage.ctrl.is_jalr ||
                    (ex_stage.ctrl.is_branch && cond);

  assign alu_out   = (ex_stage.ctrl.is_jal || ex_stage.ctrl.is_jalr) ? pc_plus4 : alu_res;
  assign store_val = rs2_fwd;
  assign next_pc   = taken ? target : pc_plus4;
  assign redirect  = ex_stage.valid && (next_pc != predicted_pc);

endmodule

`default_nettype wire

// File: logic/register_file.sv
// ****************************************
// integer register file
// ****************************************
`include "core_config.svh"
`default_nettype none

module register_file (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [4:0]            rs1,
  input  logic [4:0]            rs2,
  input  logic [4:0]            rd,
  input  logic [`CORE_XLEN-1:0] rd_val,
  input  logic                  we,
  output logic [`CORE_XLEN-1:0] rs1_val,
  output logic [`CORE_XLEN-1:0] rs2_val,
  output logic [`CORE_XLEN-1:0] regs [32]
);

  logic [`CORE_XLEN-1:0] regs_q [32];
  logic                  wr_ok;

  assign wr_ok = we && (rd != 5'd0);  // x0 stays zero

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_ok) begin
      regs_q[rd] <= rd_val;
    end
  end

  // write-through, decode sees the value wb writes this cycle
  assign rs1_val = (wr_ok && (rd == rs1)) ? rd_val : regs_q[rs1];
  assign rs2_val = (wr_ok && (rd == rs2)) ? rd_val : regs_q[rs2];
  assign regs    = regs_q;

endmodule

`default_nettype wire

// File: logic/core_memory.sv
// ****************************************
// instruction and data memory
// ****************************************
`include "core_config.svh"
`default_nettype none

module core_memory (
  input  logic                                clk,
  input  logic                                prog_we,
  input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                         prog_data,
  input  logic [`CORE_XLEN-1:0]               pc,
  input  logic [`CORE_XLEN-1:0]               data_addr,
  input  logic [`CORE_XLEN-1:0]               store_val,
  input  logic                                mem_wr,
  output logic [31:0]                         inst,
  output logic [`CORE_XLEN-1:0]               load_data
);

  localparam int imem_aw = $clog2(`CORE_IMEM_WORDS);
  localparam int dmem_aw = $clog2(`CORE_DMEM_WORDS);

  logic [31:0]           imem [`CORE_IMEM_WORDS];
  logic [`CORE_XLEN-1:0] dmem [`CORE_DMEM_WORDS] = '{default: '0};

  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;  // loaded during reset
    end
  end

  always_ff @(posedge clk) begin
    if (mem_wr) begin
      dmem[data_addr[dmem_aw+1:2]] <= store_val;
    end
  end

  // byte addresses, word arrays
  assign inst      = imem[pc[imem_aw+1:2]];
  assign load_data = dmem[data_addr[dmem_aw+1:2]];

endmodule

`default_nettype wire

// File: logic/pipelined_core.sv
// ****************************************
// five stage rv32i core
// ****************************************
`include "core_config.svh"
`default_nettype none

module pipelined_core (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                prog_we,
  input  logic [$clog2(`CORE_IMEM_WORDS)-1:0] prog_addr,
  input  logic [31:0]                         prog_data,
  output logic                                is_halted,
  output logic [`CORE_XLEN-1:0]               print_reg [32]
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  localparam logic [4:0] ecall_arg_reg = 5'd17;

  logic [`CORE_XLEN-1:0] pc_q, pc_plus4, next_pc, alu_out, store_val;
  logic [`CORE_XLEN-1:0] rs1_val, rs2_val, load_data, dec_imm;
  logic [31:0]           inst_word;
  logic [4:0]            id_rs1, id_rs2;
  logic                  stall, redirect;
  ctrl_t                 dec_ctrl, id_ctrl;
  alu_op_e               dec_alu_op;
  if_id_t                if_id_q;
  id_ex_t                id_ex_q, id_ex_d;
  ex_mem_t               ex_mem_q, ex_mem_d;
  mem_wb_t               mem_wb_q, mem_wb_d;

  assign pc_plus4  = pc_q + `CORE_XLEN'd4;  // fall-through prediction
  assign is_halted = mem_wb_q.valid && mem_wb_q.halt;

  decode_unit u_decode (.inst(if_id_q.inst), .ctrl(dec_ctrl), .alu_op(dec_alu_op),
                        .imm(dec_imm));

  assign id_ctrl = if_id_q.valid ? dec_ctrl : '0;
  assign id_rs1  = id_ctrl.is_ecall ? ecall_arg_reg : if_id_q.inst.r_view.rs1;
  assign id_rs2  = if_id_q.inst.r_view.rs2;

  hazard_unit u_hazard (.ctrl(id_ctrl), .rs1(id_rs1), .rs2(id_rs2), .ex_stage(id_ex_q),
                        .mem_stage(ex_mem_q), .stall(stall));

  register_file u_regs (.clk(clk), .rst_n(rst_n), .rs1(id_rs1), .rs2(id_rs2),
                        .rd(mem_wb_q.rd), .rd_val(mem_wb_q.rd_val),
                        .we(mem_wb_q.valid && mem_wb_q.wb_en), .rs1_val(rs1_val),
                        .rs2_val(rs2_val), .regs(print_reg));

  execute_unit u_execute (.ex_stage(id_ex_q), .mem_stage(ex_mem_q), .wb_stage(mem_wb_q),
                          .predicted_pc(if_id_q.pc), .alu_out(alu_out),
                          .store_val(store_val), .next_pc(next_pc), .redirect(redirect));

  core_memory u_mem (.clk(clk), .prog_we(prog_we), .prog_addr(prog_addr),
                     .prog_data(prog_data), .pc(pc_q), .data_addr(ex_mem_q.alu_out),
                     .store_val(ex_mem_q.store_val),
                     .mem_wr(ex_mem_q.valid && ex_mem_q.mem_wr && !is_halted),
                     .inst(inst_word), .load_data(load_data));

  always_comb begin
    id_ex_d.valid   = if_id_q.valid && !stall && !redirect;  // bubble on stall or flush
    id_ex_d.ctrl    = id_ctrl;
    id_ex_d.alu_op  = dec_alu_op;
    id_ex_d.funct3  = if_id_q.inst.r_view.funct3;
    id_ex_d.pc      = if_id_q.pc;
    id_ex_d.rs1_val = rs1_val;
    id_ex_d.rs2_val = rs2_val;
    id_ex_d.imm     = dec_imm;
    id_ex_d.rs1     = id_rs1;
    id_ex_d.rs2     = id_rs2;
    id_ex_d.rd      = if_id_q.inst.r_view.rd;
    // x17 is settled here, the stall keeps older writers out of ex and mem
    id_ex_d.halt    = id_ctrl.is_ecall && (rs1_val == `CORE_XLEN'(`CORE_HALT_CODE));
  end

  always_comb begin
    ex_mem_d.valid     = id_ex_q.valid;
    ex_mem_d.wb_en     = id_ex_q.ctrl.wb_en;
    ex_mem_d.mem_rd    = id_ex_q.ctrl.mem_rd;
    ex_mem_d.mem_wr    = id_ex_q.ctrl.mem_wr;
    ex_mem_d.halt      = id_ex_q.halt;
    ex_mem_d.alu_out   = alu_out;
    ex_mem_d.store_val = store_val;
    ex_mem_d.rd        = id_ex_q.rd;
    mem_wb_d.valid     = ex_mem_q.valid;
    mem_wb_d.wb_en     = ex_mem_q.wb_en;
    mem_wb_d.halt      = ex_mem_q.halt;
    mem_wb_d.rd        = ex_mem_q.rd;
    mem_wb_d.rd_val    = ex_mem_q.mem_rd ? load_data : ex_mem_q.alu_out;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q     <= '0;
      if_id_q  <= '0;
      id_ex_q  <= '0;
      ex_mem_q <= '0;
      mem_wb_q <= '0;
    end else if (!is_halted) begin  // frozen once the halting ecall is in wb
      if (redirect) begin
        pc_q          <= next_pc;
        if_id_q.valid <= 1'b0;
      end else if (!stall) begin
        pc_q          <= pc_plus4;
        if_id_q.valid <= 1'b1;
        if_id_q.pc    <= pc_q;
        if_id_q.inst  <= inst_word;
      end
      id_ex_q  <= id_ex_d;
      ex_mem_q <= ex_mem_d;
      mem_wb_q <= mem_wb_d;
    end
  end

endmodule

`default_nettype wire

// File: bench/core_properties.sv
// ****************************************
// core assertions
// ****************************************
`include "core_config.svh"
`default_nettype none

module core_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  is_halted,
  input logic [`CORE_XLEN-1:0] x0_val
);
  timeunit 1ns;
  timeprecision 100ps;

  // halt is sticky until the next reset
  halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) is_halted |=> is_halted)
    else $error("is_halted fell while rst_n was high");

  x0_zero: assert property (@(posedge clk) x0_val == '0)
    else $error("x0 holds a nonzero value");

  // first edge out of reset
  halt_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !is_halted)
    else $error("is_halted high in the first cycle after reset");

endmodule

`default_nettype wire

// File: bench/core_tb.sv
// ****************************************
// pipelined core testbench
// ****************************************
`include "core_config.svh"
`default_nettype none

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [31:0][31:0] reg_image_t;

  localparam int         imem_words = `CORE_IMEM_WORDS;
  localparam logic [6:0] op_r       = 7'b0110011;
  localparam logic [6:0] op_i       = 7'b0010011;
  localparam logic [6:0] op_lui     = 7'b0110111;
  localparam logic [6:0] op_load    = 7'b0000011;
  localparam logic [6:0] op_store   = 7'b0100011;
  localparam logic [6:0] op_branch  = 7'b1100011;
  localparam logic [6:0] op_jal     = 7'b1101111;
  localparam logic [6:0] op_jalr    = 7'b1100111;
  localparam logic [6:0] op_system  = 7'b1110011;

  logic        clk;
  logic        rst_n;
  logic        prog_we;
  logic [7:0]  prog_addr;
  logic [31:0] prog_data;
  logic        is_halted;
  logic [31:0] print_reg [32];
  logic [31:0] prog [imem_words];
  logic [31:0] lfsr_q;
  reg_image_t  exp_regs;
  logic        check_go;
  logic        check_done;
  int          value_errs;
  int          other_errs;

  pipelined_core i_dut (.clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
                        .prog_data(prog_data), .is_halted(is_halted), .print_reg(print_reg));

  bind pipelined_core core_properties u_props (.clk(clk), .rst_n(rst_n),
                                               .is_halted(is_halted), .x0_val(print_reg[0]));

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, op_r};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
  endfunction

  task automatic build_program();
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev_rd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    prev_rd = 5'd1;
    for (int i = 0; i < 40; i++) begin
      kind = 2'(rand_bits(2));
      rd   = 5'(rand_bits(4) % 15 + 1);
      rs1  = (rand_bits(1) != 0) ? prev_rd : 5'(rand_bits(4));  // chain on last result
      rs2  = 5'(rand_bits(4));
      f3   = 3'(rand_bits(3));
      alt  = (rand_bits(1) != 0);
      imm  = 12'(rand_bits(12));
      if (f3 == 3'b011)
        f3 = 3'b000;  // no sltu in this core
      case (kind)
        2'd0: prog[i] = enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd);
        2'd1: begin
          if (f3 == 3'b001 || f3 == 3'b101)
            imm[11:5] = (alt && f3 == 3'b101) ? 7'h20 : 7'h00;  // shamt only
          prog[i] = enc_i(imm, rs1, f3, rd, op_i);
        end
        2'd2: prog[i] = {20'(rand_bits(20)), rd, op_lui};
        default: prog[i] = enc_i(imm, rs1, 3'b000, rd, op_i);
      endcase
      prev_rd = rd;
    end
    prog[40] = enc_s(12'd64, 5'd5, 5'd0);
    prog[41] = enc_i(12'd64, 5'd0, 3'b010, 5'd16, op_load);
    prog[42] = enc_r(7'h00, 5'd1, 5'd16, 3'b000, 5'd18);  // load-use
    prog[43] = enc_b(13'd12, 5'd16, 5'd16, 3'b000);       // beq taken to 46
    prog[44] = enc_i(12'd1, 5'd0, 3'b000, 5'd20, op_i);
    prog[45] = enc_i(12'd2, 5'd0, 3'b000, 5'd21, op_i);
    prog[46] = enc_b(13'd8, 5'd0, 5'd0, 3'b001);          // bne never taken
    prog[47] = enc_i(12'd3, 5'd0, 3'b000, 5'd22, op_i);
    prog[48] = enc_j(21'd16, 5'd23);                      // call 52
    prog[49] = enc_i(12'd5, 5'd0, 3'b000, 5'd24, op_i);
    prog[50] = enc_j(21'd16, 5'd0);                       // over 51 to 54
    prog[51] = enc_i(12'd6, 5'd0, 3'b000, 5'd25, op_i);
    prog[52] = enc_i(12'd7, 5'd0, 3'b000, 5'd26, op_i);
    prog[53] = enc_i(12'd0, 5'd23, 3'b000, 5'd27, op_jalr);  // return to 49
    prog[54] = enc_i(12'd5, 5'd0, 3'b000, 5'd17, op_i);
    prog[55] = 32'h0000_0073;  // ecall with x17 still 5
    prog[56] = enc_i(12'(`CORE_HALT_CODE), 5'd0, 3'b000, 5'd17, op_i);
    prog[57] = 32'h0000_0073;
    // filler past the halt that must never retire
    for (int a = 58; a < imem_words; a++)
      prog[a] = enc_i(12'(a), 5'd0, 3'b000, 5'(a % 15 + 1), op_i);
  endtask

  // architectural model, one instruction per step
  function automatic reg_image_t iss_run();
    reg_image_t  x;
    logic [31:0] dmem [`CORE_DMEM_WORDS];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] addr;
    logic [31:0] res;
    logic        take;
    logic        halted;
    x      = '0;
    pc     = '0;
    halted = 1'b0;
    for (int k = 0; k < `CORE_DMEM_WORDS; k++)
      dmem[k] = '0;
    for (int step = 0; step < 4096 && !halted; step++) begin
      ins   = prog[pc[9:2]];
      a     = x[ins[19:15]];
      b     = x[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      npc   = pc + 32'd4;
      case (ins[6:0])
        op_r, op_i: begin
          if (ins[6:0] == op_i)
            b = imm_i;
          case (ins[14:12])
            3'b000: res = (ins[6:0] == op_r && ins[30]) ? a - b : a + b;
            3'b001: res = a << b[4:0];
            3'b010: res = {31'd0, $signed(a) < $signed(b)};
            3'b100: res = a ^ b;
            3'b101: begin
              if (ins[30])
                res = $signed(a) >>> b[4:0];
              else
                res = a >> b[4:0];
            end
            3'b110: res = a | b;
            default: res = a & b;
          endcase
          x[ins[11:7]] = res;
        end
        op_lui: x[ins[11:7]] = {ins[31:12], 12'd0};
        op_load: begin
          addr         = a + imm_i;
          x[ins[11:7]] = dmem[addr[9:2]];
        end
        op_store: begin
          addr             = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
          dmem[addr[9:2]] = b;
        end
        op_branch: begin
          case (ins[14:12])
            3'b000:  take = (a == b);
            3'b001:  take = (a != b);
            3'b100:  take = $signed(a) < $signed(b);
            default: take = $signed(a) >= $signed(b);
          endcase
          if (take)
            npc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
        op_jal: begin
          x[ins[11:7]] = pc + 32'd4;
          npc          = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        end
        op_jalr: begin
          x[ins[11:7]] = pc + 32'd4;
          npc          = (a + imm_i) & ~32'd1;
        end
        op_system: halted = (x[17] == `CORE_HALT_CODE);
        default: ;
      endcase
      x[0] = '0;
      pc   = npc;
    end
    return x;
  endfunction

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(negedge clk) begin
    if (check_go && !check_done) begin
      for (int i = 0; i < 32; i++) begin
        assert (print_reg[i] === exp_regs[i]) else begin
          $display("** Error at %0d ns: print_reg[%0d] = %h, expected %h", $time, i,
                   print_reg[i], exp_regs[i]);
          value_errs++;
        end
      end
      check_done = 1'b1;
    end
  end

  initial begin
    int cycles;
    rst_n      = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    check_go   = 1'b0;
    check_done = 1'b0;
    value_errs = 0;
    other_errs = 0;
    lfsr_q     = 32'h77c84ac6;
    build_program();
    exp_regs = iss_run();
    // whole imem through the program port while in reset
    for (int a = 0; a < imem_words; a++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = 8'(a);
      prog_data = prog[a];
    end
    @(negedge clk);
    prog_we = 1'b0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (!is_halted) else begin
      $display("is_halted is high right after reset");
      other_errs++;
    end
    cycles = 0;
    while (!is_halted && cycles < 2000) begin
      @(negedge clk);
      cycles++;
    end
    assert (is_halted) else begin
      $display("timeout, is_halted still low after 2000 cycles");
      other_errs++;
    end
    if (is_halted) begin
      check_go = 1'b1;
      cycles   = 0;
      while (!check_done && cycles < 10) begin
        @(negedge clk);
        cycles++;
      end
      assert (check_done) else begin
        $display("register compare did not run after the halt");
        other_errs++;
      end
    end
    $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/decode_unit.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/register_file.sv
logic/core_memory.sv
logic/pipelined_core.sv
bench/core_properties.sv
bench/core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = core_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
